// File: bench/pipeline_tail_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_tail_assertions (
    input logic                   clk_display,
    input logic                   rstn_display,
    input logic                   pixel_ready,
    input display_pkg::fb_write_t wr,
    input logic                   front_sel,
    input logic                   draw_ack,
    input logic                   vga_hsync
);

    // Read by the testbench at the end of the run
    int assert_errors = 0;

    // Input held off for two cycles means nothing to write
    no_write_while_held: assert property (@(posedge clk_display) disable iff (!rstn_display)
        (!pixel_ready && $past(!pixel_ready)) |-> !wr.en)
        else begin
            assert_errors++;
            $error("write enable while pixel_ready is low");
        end

    swap_only_on_ack: assert property (@(posedge clk_display) disable iff (!rstn_display)
        (front_sel != $past(front_sel)) |-> $past(draw_ack))
        else begin
            assert_errors++;
            $error("front_sel changed without draw_ack");
        end

    hsync_pulse_width: assert property (@(posedge clk_display) disable iff (!rstn_display)
        $fell(vga_hsync) |-> !vga_hsync [*display_pkg::h_sync] ##1 vga_hsync)
        else begin
            assert_errors++;
            $error("hsync pulse width differs from h_sync");
        end

endmodule

bind pipeline_tail pipeline_tail_assertions i_pipeline_tail_assertions (
    .clk_display  (clk_display),
    .rstn_display (rstn_display),
    .pixel_ready  (pixel_ready),
    .wr           (dm_wr),
    .front_sel    (front_sel),
    .draw_ack     (draw_ack),
    .vga_hsync    (vga_hsync)
);

`default_nettype wire

// File: bench/pipeline_tail_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_tail_tb;

    localparam int n_frames   = 4;
    localparam int clk_period = 20;
    localparam int hs_start   = display_pkg::h_active + display_pkg::h_front;
    localparam int vs_start   = display_pkg::v_active + display_pkg::v_front;
    localparam longint watchdog_ns = longint'(n_frames + 4) * display_pkg::h_total *
        display_pkg::v_total * clk_period * 2;

    logic                   clk_display;
    logic                   rstn_display;
    logic                   pixel_valid;
    display_pkg::pixel_in_t pixel_data;
    logic                   pixel_ready;
    logic                   vga_hsync;
    logic                   vga_vsync;
    logic [3:0]             vga_red;
    logic [3:0]             vga_green;
    logic [3:0]             vga_blue;

    integer      seed;
    int          error_count;
    // Reference model of both buffers and the shown one
    logic [11:0] model_mem [2][display_pkg::buf_depth];
    bit          model_front;
    bit          pending_swap;
    int          swap_count;
    // Raster position of what the pins show now
    bit          locked;
    logic        prev_vsync;
    int          ph;
    int          pv;

    pipeline_tail i_pipeline_tail (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .pixel_valid  (pixel_valid),
        .pixel_data   (pixel_data),
        .pixel_ready  (pixel_ready),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

    initial begin
        clk_display = 1'b0;
        forever #(clk_period / 2) clk_display = ~clk_display;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_idle_pins(input string name);
        check_value({name, " hsync"}, 1, vga_hsync);
        check_value({name, " vsync"}, 1, vga_vsync);
        check_value({name, " color"}, 0, {vga_red, vga_green, vga_blue});
        check_value({name, " pixel_ready"}, 1, pixel_ready);
    endtask

    // Screen pixel (h, v) shows buffer pixel (h/2, v/2), black elsewhere
    function automatic logic [11:0] expected_color(input int h, input int v);
        if (h < display_pkg::h_active && v < display_pkg::v_active) begin
            return model_mem[model_front][(v >> display_pkg::scale_shift) *
                display_pkg::buf_width + (h >> display_pkg::scale_shift)];
        end
        return 12'h000;
    endfunction

    // Present one pixel and hold it until the handshake completes
    task automatic send_pixel(input display_pkg::pixel_in_t p);
        logic got;
        int   addr;
        got = 1'b0;
        pixel_valid <= 1'b1;
        pixel_data  <= p;
        while (!got) begin
            @(negedge clk_display);
            got = pixel_ready;
            @(posedge clk_display);
        end
        addr = p.meta.y * display_pkg::buf_width + p.meta.x;
        model_mem[~model_front][addr] = p.color;
        if (p.meta.last) begin
            pending_swap = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Pin monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clk_display) begin
        if (rstn_display) begin
            // Start of the vsync pulse fixes the raster position
            if (!locked && prev_vsync && !vga_vsync) begin
                locked = 1'b1;
                ph = 0;
                pv = vs_start;
            end
            if (pending_swap && pixel_ready) begin
                if (locked) begin
                    check_value("ready_rise_line", vs_start, pv);
                    check_value("ready_rise_column", 1, ph);
                end else begin
                    error_count++;
                    $display("pixel_ready returned before any vertical sync was seen");
                end
                model_front  = ~model_front;
                pending_swap = 1'b0;
                swap_count++;
            end else if (!pending_swap) begin
                check_value("pixel_ready", 1, pixel_ready);
            end
            if (locked) begin
                check_value("hsync", !(ph >= hs_start && ph < hs_start + display_pkg::h_sync),
                    vga_hsync);
                check_value("vsync", !(pv >= vs_start && pv < vs_start + display_pkg::v_sync),
                    vga_vsync);
                check_value("color", expected_color(ph, pv), {vga_red, vga_green, vga_blue});
                ph++;
                if (ph == display_pkg::h_total) begin
                    ph = 0;
                    pv = (pv + 1) % display_pkg::v_total;
                end
            end else begin
                // Blank buffer 0 stays on screen until the first swap
                check_value("color_before_swap", 0, {vga_red, vga_green, vga_blue});
            end
            prev_vsync = vga_vsync;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout after %0d ns, the run did not finish", watchdog_ns);
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int                     order [display_pkg::buf_depth];
        int                     j;
        int                     tmp;
        int                     gap;
        display_pkg::pixel_in_t p;
        seed = 32'h91e35e60;
        error_count = 0;
        model_front = 1'b0;
        pending_swap = 1'b0;
        swap_count = 0;
        locked = 1'b0;
        prev_vsync = 1'b1;
        ph = 0;
        pv = 0;
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < display_pkg::buf_depth; a++) begin
                model_mem[b][a] = 12'h000;
            end
        end
        rstn_display = 1'b0;
        pixel_valid = 1'b0;
        pixel_data = '0;
        repeat (3) begin
            @(negedge clk_display);
            check_idle_pins("reset");
        end
        @(posedge clk_display);
        rstn_display <= 1'b1;
        repeat (2) begin
            @(negedge clk_display);
            check_idle_pins("after reset");
        end
        @(posedge clk_display);

        for (int f = 0; f < n_frames; f++) begin
            // Every buffer pixel once, in shuffled order
            for (int i = 0; i < display_pkg::buf_depth; i++) begin
                order[i] = i;
            end
            for (int i = display_pkg::buf_depth - 1; i > 0; i--) begin
                j = $unsigned($random(seed)) % (i + 1);
                tmp = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
            for (int i = 0; i < display_pkg::buf_depth; i++) begin
                p.color = 12'($random(seed));
                p.meta.x = display_pkg::buf_x_w'(order[i] % display_pkg::buf_width);
                p.meta.y = display_pkg::buf_y_w'(order[i] / display_pkg::buf_width);
                p.meta.last = (i == display_pkg::buf_depth - 1);
                send_pixel(p);
                gap = $unsigned($random(seed)) % 4;
                if (gap != 0) begin
                    pixel_valid <= 1'b0;
                    repeat (gap) @(posedge clk_display);
                end
            end
        end
        pixel_valid <= 1'b0;

        // Last frame goes on screen, then one full frame is checked
        while (pending_swap) @(negedge clk_display);
        repeat (display_pkg::h_total * (display_pkg::v_total + 1)) @(negedge clk_display);

        check_value("swap_count", n_frames, swap_count);
        check_value("assertion_failures", 0,
            i_pipeline_tail.i_pipeline_tail_assertions.assert_errors);
        $display("Checks done with %0d errors", error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/display_pkg.sv
verilog/frame_buffer.sv
verilog/drawing_manager.sv
verilog/buffer_swap_control.sv
verilog/vga_scanout.sv
verilog/pipeline_tail.sv
bench/pipeline_tail_assertions.sv
bench/pipeline_tail_tb.sv

// File: verilog/buffer_swap_control.sv
`timescale 1ns/10ps
`default_nettype none

module buffer_swap_control (
    input  logic clk_display,
    input  logic rstn_display,
    input  logic vga_vsync,
    input  logic frame_done,
    output logic front_sel,
    output logic draw_ack
);

    logic vsync_d;
    logic vsync_start;
    logic swap;

    // Idle level of vsync is high, so no false edge out of reset
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vsync_d <= 1'b1;
        end else begin
            vsync_d <= vga_vsync;
        end
    end

    // Falling edge of the active low pulse marks vertical blanking
    assign vsync_start = vsync_d && !vga_vsync;

    // Swap only when a whole frame sits in the back buffer
    assign swap = vsync_start && frame_done;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            front_sel <= 1'b0;
        end else if (swap) begin
            front_sel <= !front_sel;
        end
    end

    // Drawing side released in the swap cycle
    assign draw_ack = swap;

endmodule

`default_nettype wire

// File: verilog/display_pkg.sv
`default_nettype none

package display_pkg;

    ////////////////////////////////////////////////////////////
    // Video timing, tiny mode for short simulations
    ////////////////////////////////////////////////////////////

    // Horizontal timing in clocks
    localparam int h_active = 16;
    localparam int h_front  = 2;
    localparam int h_sync   = 3;
    localparam int h_back   = 3;
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    // Vertical timing in lines, both syncs active low
    localparam int v_active = 12;
    localparam int v_front  = 1;
    localparam int v_sync   = 2;
    localparam int v_back   = 1;
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    localparam int h_cnt_w = $clog2(h_total);
    localparam int v_cnt_w = $clog2(v_total);

    ////////////////////////////////////////////////////////////
    // Frame buffer geometry
    ////////////////////////////////////////////////////////////

    localparam int buf_width   = 8;
    localparam int buf_height  = 6;
    localparam int buf_depth   = buf_width * buf_height;
    localparam int buf_addr_w  = $clog2(buf_depth);
    localparam int buf_x_w     = $clog2(buf_width);
    localparam int buf_y_w     = $clog2(buf_height);
    // Screen coordinate >> scale_shift gives buffer coordinate
    localparam int scale_shift = 1;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } color_t;

    typedef struct packed {
        logic [buf_x_w-1:0] x;
        logic [buf_y_w-1:0] y;
        logic               last;
    } pixel_meta_t;

    // Stream payload
    typedef struct packed {
        color_t      color;
        pixel_meta_t meta;
    } pixel_in_t;

    // Write port bundle
    typedef struct packed {
        logic                  en;
        logic [buf_addr_w-1:0] addr;
        color_t                data;
    } fb_write_t;

    typedef enum logic {
        dm_draw,
        dm_wait_swap
    } dm_state_t;

endpackage

`default_nettype wire

// File: verilog/drawing_manager.sv
`timescale 1ns/10ps
`default_nettype none

module drawing_manager (
    input  logic                    clk_display,
    input  logic                    rstn_display,
    input  logic                    pixel_valid,
    input  display_pkg::pixel_in_t  pixel_data,
    output logic                    pixel_ready,
    output display_pkg::fb_write_t  wr,
    output logic                    frame_done,
    input  logic                    draw_ack
);

    display_pkg::dm_state_t state;

    logic                               accept;
    logic [display_pkg::buf_addr_w-1:0] pix_addr;

    logic                               wr_en_q;
    logic [display_pkg::buf_addr_w-1:0] wr_addr_q;
    display_pkg::color_t                wr_data_q;

    // Input is open only while drawing
    assign pixel_ready = (state == display_pkg::dm_draw);
    assign frame_done  = (state == display_pkg::dm_wait_swap);
    assign accept      = pixel_valid && pixel_ready;

    // Row major address, y * width + x
    assign pix_addr = display_pkg::buf_addr_w'(
        pixel_data.meta.y * display_pkg::buf_width + pixel_data.meta.x);

    ////////////////////////////////////////////////////////////
    // Frame state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            state <= display_pkg::dm_draw;
        end else begin
            case (state)
                display_pkg::dm_draw: begin
                    if (accept && pixel_data.meta.last) begin
                        state <= display_pkg::dm_wait_swap;
                    end
                end
                display_pkg::dm_wait_swap: begin
                    // Back buffer is now on screen, start the next frame
                    if (draw_ack) begin
                        state <= display_pkg::dm_draw;
                    end
                end
                default: state <= display_pkg::dm_draw;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Write port, one cycle after acceptance
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= accept;
        end
    end

    always_ff @(posedge clk_display) begin
        if (accept) begin
            wr_addr_q <= pix_addr;
            wr_data_q <= pixel_data.color;
        end
    end

    always_comb begin
        wr.en   = wr_en_q;
        wr.addr = wr_addr_q;
        wr.data = wr_data_q;
    end

endmodule

`default_nettype wire

// File: verilog/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
    input  logic                                  clk_display,
    input  display_pkg::fb_write_t                wr,
    input  logic [display_pkg::buf_addr_w-1:0]    read_addr,
    output display_pkg::color_t                   read_data
);

    display_pkg::color_t mem [display_pkg::buf_depth];

    // Blank picture at power up
    initial begin
        for (int i = 0; i < display_pkg::buf_depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_display) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk_display) begin
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

// File: verilog/pipeline_tail.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_tail (
    input  logic                   clk_display,
    input  logic                   rstn_display,
    input  logic                   pixel_valid,
    input  display_pkg::pixel_in_t pixel_data,
    output logic                   pixel_ready,
    output logic                   vga_hsync,
    output logic                   vga_vsync,
    output logic [3:0]             vga_red,
    output logic [3:0]             vga_green,
    output logic [3:0]             vga_blue
);

    display_pkg::fb_write_t             dm_wr;
    display_pkg::fb_write_t             fb_0_wr;
    display_pkg::fb_write_t             fb_1_wr;
    logic [display_pkg::buf_addr_w-1:0] read_addr;
    display_pkg::color_t                fb_0_rd;
    display_pkg::color_t                fb_1_rd;
    display_pkg::color_t                front_rd;
    logic                               frame_done;
    logic                               draw_ack;
    logic                               front_sel;

    ////////////////////////////////////////////////////////////
    // Buffer routing
    ////////////////////////////////////////////////////////////

    // Writes land only in the back buffer
    always_comb begin
        fb_0_wr    = dm_wr;
        fb_1_wr    = dm_wr;
        fb_0_wr.en = dm_wr.en && front_sel;
        fb_1_wr.en = dm_wr.en && !front_sel;
    end

    // front_sel 0 shows buffer 0
    assign front_rd = front_sel ? fb_1_rd : fb_0_rd;

    drawing_manager i_drawing_manager (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .pixel_valid  (pixel_valid),
        .pixel_data   (pixel_data),
        .pixel_ready  (pixel_ready),
        .wr           (dm_wr),
        .frame_done   (frame_done),
        .draw_ack     (draw_ack)
    );

    buffer_swap_control i_buffer_swap_control (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .vga_vsync    (vga_vsync),
        .frame_done   (frame_done),
        .front_sel    (front_sel),
        .draw_ack     (draw_ack)
    );

    frame_buffer fb_0 (
        .clk_display (clk_display),
        .wr          (fb_0_wr),
        .read_addr   (read_addr),
        .read_data   (fb_0_rd)
    );

    frame_buffer fb_1 (
        .clk_display (clk_display),
        .wr          (fb_1_wr),
        .read_addr   (read_addr),
        .read_data   (fb_1_rd)
    );

    vga_scanout i_vga_scanout (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .read_addr    (read_addr),
        .read_data    (front_rd),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

endmodule

`default_nettype wire

// File: verilog/vga_scanout.sv
`timescale 1ns/10ps
`default_nettype none

module vga_scanout (
    input  logic                               clk_display,
    input  logic                               rstn_display,
    output logic [display_pkg::buf_addr_w-1:0] read_addr,
    input  display_pkg::color_t                read_data,
    output logic                               vga_hsync,
    output logic                               vga_vsync,
    output logic [3:0]                         vga_red,
    output logic [3:0]                         vga_green,
    output logic [3:0]                         vga_blue
);

    logic [display_pkg::h_cnt_w-1:0] h_cnt;
    logic [display_pkg::v_cnt_w-1:0] v_cnt;
    logic                            h_last;
    logic                            v_last;
    logic                            active;
    logic                            hsync_n;
    logic                            vsync_n;
    logic                            active_q;
    logic [display_pkg::buf_x_w-1:0] buf_x;
    logic [display_pkg::buf_y_w-1:0] buf_y;
    display_pkg::color_t             pixel;

    ////////////////////////////////////////////////////////////
    // Raster counters
    ////////////////////////////////////////////////////////////

    assign h_last = (h_cnt == display_pkg::h_cnt_w'(display_pkg::h_total - 1));
    assign v_last = (v_cnt == display_pkg::v_cnt_w'(display_pkg::v_total - 1));

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Sync windows and upscaled read address
    ////////////////////////////////////////////////////////////

    assign active = (h_cnt < display_pkg::h_active) && (v_cnt < display_pkg::v_active);

    assign hsync_n = !((h_cnt >= display_pkg::h_active + display_pkg::h_front) &&
        (h_cnt < display_pkg::h_active + display_pkg::h_front + display_pkg::h_sync));
    assign vsync_n = !((v_cnt >= display_pkg::v_active + display_pkg::v_front) &&
        (v_cnt < display_pkg::v_active + display_pkg::v_front + display_pkg::v_sync));

    // Each buffer pixel covers a 2x2 block on screen
    assign buf_x = display_pkg::buf_x_w'(h_cnt >> display_pkg::scale_shift);
    assign buf_y = display_pkg::buf_y_w'(v_cnt >> display_pkg::scale_shift);

    // Park on address 0 in blanking, keeps reads in range
    assign read_addr = active ?
        display_pkg::buf_addr_w'(buf_y * display_pkg::buf_width + buf_x) : '0;

    // One stage to line up with the memory read
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            active_q  <= 1'b0;
        end else begin
            vga_hsync <= hsync_n;
            vga_vsync <= vsync_n;
            active_q  <= active;
        end
    end

    // Black outside the picture
    assign pixel     = active_q ? read_data : '0;
    assign vga_red   = pixel.red;
    assign vga_green = pixel.green;
    assign vga_blue  = pixel.blue;

endmodule

`default_nettype wire
